// File: rs_div.f
+incdir+verification
src/rs_div_pkg.sv
src/rs_tag_match.sv
src/rs_issue_select.sv
src/rs_entry_array.sv
src/rs_div.sv
verification/rs_div_tb.sv

// File: src/rs_div.sv
`timescale 1ns/1ns

module rs_div #(
    parameter int DEPTH = 16
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          dispatch,
    input  logic [rs_div_pkg::PC_W-1:0]   dispatch_pc,
    input  logic [rs_div_pkg::TAG_W-1:0]  dispatch_rd,
    input  rs_div_pkg::div_op_e           dispatch_op,
    input  logic [rs_div_pkg::TAG_W-1:0]  src1_tag,
    input  logic [rs_div_pkg::DATA_W-1:0] src1_data,
    input  logic                          src1_ready,
    input  logic [rs_div_pkg::TAG_W-1:0]  src2_tag,
    input  logic [rs_div_pkg::DATA_W-1:0] src2_data,
    input  logic                          src2_ready,
    input  logic                          alu_valid,
    input  logic [rs_div_pkg::TAG_W-1:0]  alu_dest,
    input  logic [rs_div_pkg::DATA_W-1:0] alu_result,
    input  logic                          mul_valid,
    input  logic [rs_div_pkg::TAG_W-1:0]  mul_dest,
    input  logic [rs_div_pkg::DATA_W-1:0] mul_result,
    input  logic                          div_valid,
    input  logic [rs_div_pkg::TAG_W-1:0]  div_dest,
    input  logic [rs_div_pkg::DATA_W-1:0] div_result,
    input  logic                          load_valid,
    input  logic [rs_div_pkg::TAG_W-1:0]  load_tag,
    input  logic [rs_div_pkg::DATA_W-1:0] load_data,
    output logic                          issue_valid,
    output logic [rs_div_pkg::PC_W-1:0]   issue_pc,
    output logic [rs_div_pkg::TAG_W-1:0]  issue_rd,
    output rs_div_pkg::div_op_e           issue_op,
    output logic [rs_div_pkg::DATA_W-1:0] issue_src1,
    output logic [rs_div_pkg::DATA_W-1:0] issue_src2,
    output logic                          full
);

    localparam int PTR_W = $clog2(DEPTH);

    logic                          res1_ready;  // dispatch operands after bus capture
    logic [rs_div_pkg::DATA_W-1:0] res1_data;
    logic                          res2_ready;
    logic [rs_div_pkg::DATA_W-1:0] res2_data;
    logic [DEPTH-1:0]              ready;
    logic [PTR_W-1:0]              head;
    logic                          grant_valid;
    logic [PTR_W-1:0]              grant_index;

    rs_tag_match u_capture1 (
        .tag        (src1_tag),
        .in_ready   (src1_ready),
        .in_data    (src1_data),
        .alu_valid  (alu_valid),
        .alu_dest   (alu_dest),
        .alu_result (alu_result),
        .mul_valid  (mul_valid),
        .mul_dest   (mul_dest),
        .mul_result (mul_result),
        .div_valid  (div_valid),
        .div_dest   (div_dest),
        .div_result (div_result),
        .load_valid (load_valid),
        .load_tag   (load_tag),
        .load_data  (load_data),
        .out_ready  (res1_ready),
        .out_data   (res1_data)
    );

    rs_tag_match u_capture2 (
        .tag        (src2_tag),
        .in_ready   (src2_ready),
        .in_data    (src2_data),
        .alu_valid  (alu_valid),
        .alu_dest   (alu_dest),
        .alu_result (alu_result),
        .mul_valid  (mul_valid),
        .mul_dest   (mul_dest),
        .mul_result (mul_result),
        .div_valid  (div_valid),
        .div_dest   (div_dest),
        .div_result (div_result),
        .load_valid (load_valid),
        .load_tag   (load_tag),
        .load_data  (load_data),
        .out_ready  (res2_ready),
        .out_data   (res2_data)
    );

    rs_entry_array #(
        .DEPTH (DEPTH)
    ) u_entries (
        .clk         (clk),
        .reset       (reset),
        .dispatch    (dispatch),
        .dispatch_pc (dispatch_pc),
        .dispatch_rd (dispatch_rd),
        .dispatch_op (dispatch_op),
        .src1_tag    (src1_tag),
        .src1_ready  (res1_ready),
        .src1_data   (res1_data),
        .src2_tag    (src2_tag),
        .src2_ready  (res2_ready),
        .src2_data   (res2_data),
        .alu_valid   (alu_valid),
        .alu_dest    (alu_dest),
        .alu_result  (alu_result),
        .mul_valid   (mul_valid),
        .mul_dest    (mul_dest),
        .mul_result  (mul_result),
        .div_valid   (div_valid),
        .div_dest    (div_dest),
        .div_result  (div_result),
        .load_valid  (load_valid),
        .load_tag    (load_tag),
        .load_data   (load_data),
        .grant_valid (grant_valid),
        .grant_index (grant_index),
        .ready       (ready),
        .head        (head),
        .full        (full),
        .issue_valid (issue_valid),
        .issue_pc    (issue_pc),
        .issue_rd    (issue_rd),
        .issue_op    (issue_op),
        .issue_src1  (issue_src1),
        .issue_src2  (issue_src2)
    );

    rs_issue_select #(
        .DEPTH (DEPTH)
    ) u_select (
        .ready       (ready),
        .head        (head),
        .grant_valid (grant_valid),
        .grant_index (grant_index)
    );

endmodule

// File: src/rs_div_pkg.sv
package rs_div_pkg;

    localparam int TAG_W  = 8;  // physical register tag
    localparam int DATA_W = 32;
    localparam int PC_W   = 32;

    typedef enum logic [3:0] {
        OP_DIV  = 4'b0100,  // signed quotient
        OP_DIVU = 4'b0101,
        OP_REM  = 4'b0110,  // signed remainder
        OP_REMU = 4'b0111
    } div_op_e;

    localparam int BUS_COUNT = 4;

    // lower index wins when several buses carry the same tag
    localparam int BUS_ALU  = 0;
    localparam int BUS_MUL  = 1;
    localparam int BUS_DIV  = 2;
    localparam int BUS_LOAD = 3;

endpackage

// File: src/rs_entry_array.sv
`timescale 1ns/1ns

module rs_entry_array #(
    parameter int DEPTH = 16
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          dispatch,
    input  logic [rs_div_pkg::PC_W-1:0]   dispatch_pc,
    input  logic [rs_div_pkg::TAG_W-1:0]  dispatch_rd,
    input  rs_div_pkg::div_op_e           dispatch_op,
    input  logic [rs_div_pkg::TAG_W-1:0]  src1_tag,
    input  logic                          src1_ready,
    input  logic [rs_div_pkg::DATA_W-1:0] src1_data,
    input  logic [rs_div_pkg::TAG_W-1:0]  src2_tag,
    input  logic                          src2_ready,
    input  logic [rs_div_pkg::DATA_W-1:0] src2_data,
    input  logic                          alu_valid,
    input  logic [rs_div_pkg::TAG_W-1:0]  alu_dest,
    input  logic [rs_div_pkg::DATA_W-1:0] alu_result,
    input  logic                          mul_valid,
    input  logic [rs_div_pkg::TAG_W-1:0]  mul_dest,
    input  logic [rs_div_pkg::DATA_W-1:0] mul_result,
    input  logic                          div_valid,
    input  logic [rs_div_pkg::TAG_W-1:0]  div_dest,
    input  logic [rs_div_pkg::DATA_W-1:0] div_result,
    input  logic                          load_valid,
    input  logic [rs_div_pkg::TAG_W-1:0]  load_tag,
    input  logic [rs_div_pkg::DATA_W-1:0] load_data,
    input  logic                          grant_valid,
    input  logic [$clog2(DEPTH)-1:0]      grant_index,
    output logic [DEPTH-1:0]              ready,
    output logic [$clog2(DEPTH)-1:0]      head,
    output logic                          full,
    output logic                          issue_valid,
    output logic [rs_div_pkg::PC_W-1:0]   issue_pc,
    output logic [rs_div_pkg::TAG_W-1:0]  issue_rd,
    output rs_div_pkg::div_op_e           issue_op,
    output logic [rs_div_pkg::DATA_W-1:0] issue_src1,
    output logic [rs_div_pkg::DATA_W-1:0] issue_src2
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = PTR_W + 1;

    logic [rs_div_pkg::PC_W-1:0]   pc_q   [DEPTH];
    logic [rs_div_pkg::TAG_W-1:0]  rd_q   [DEPTH];
    rs_div_pkg::div_op_e           op_q   [DEPTH];
    logic [rs_div_pkg::TAG_W-1:0]  tag1_q [DEPTH];
    logic [rs_div_pkg::TAG_W-1:0]  tag2_q [DEPTH];
    logic [rs_div_pkg::DATA_W-1:0] data1_q [DEPTH];
    logic [rs_div_pkg::DATA_W-1:0] data2_q [DEPTH];
    logic [DEPTH-1:0]              busy_q;  // slot holds a live entry
    logic [DEPTH-1:0]              rdy1_q;
    logic [DEPTH-1:0]              rdy2_q;
    logic [PTR_W-1:0]              head_q;
    logic [PTR_W-1:0]              tail_q;
    logic [CNT_W-1:0]              count_q;  // slots from head to tail

    wire [DEPTH-1:0]              wake1_ready;
    wire [DEPTH-1:0]              wake2_ready;
    wire [rs_div_pkg::DATA_W-1:0] wake1_data [DEPTH];
    wire [rs_div_pkg::DATA_W-1:0] wake2_data [DEPTH];

    logic alloc;
    logic retire;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full   = (count_q == CNT_W'(DEPTH));
    assign alloc  = dispatch && !full;
    assign retire = (count_q != '0) && !busy_q[head_q];  // head slot already issued
    assign ready  = busy_q & rdy1_q & rdy2_q;
    assign head   = head_q;

    for (genvar g = 0; g < DEPTH; g++) begin : g_wake
        rs_tag_match u_match1 (
            .tag        (tag1_q[g]),
            .in_ready   (rdy1_q[g]),
            .in_data    (data1_q[g]),
            .alu_valid  (alu_valid),
            .alu_dest   (alu_dest),
            .alu_result (alu_result),
            .mul_valid  (mul_valid),
            .mul_dest   (mul_dest),
            .mul_result (mul_result),
            .div_valid  (div_valid),
            .div_dest   (div_dest),
            .div_result (div_result),
            .load_valid (load_valid),
            .load_tag   (load_tag),
            .load_data  (load_data),
            .out_ready  (wake1_ready[g]),
            .out_data   (wake1_data[g])
        );

        rs_tag_match u_match2 (
            .tag        (tag2_q[g]),
            .in_ready   (rdy2_q[g]),
            .in_data    (data2_q[g]),
            .alu_valid  (alu_valid),
            .alu_dest   (alu_dest),
            .alu_result (alu_result),
            .mul_valid  (mul_valid),
            .mul_dest   (mul_dest),
            .mul_result (mul_result),
            .div_valid  (div_valid),
            .div_dest   (div_dest),
            .div_result (div_result),
            .load_valid (load_valid),
            .load_tag   (load_tag),
            .load_data  (load_data),
            .out_ready  (wake2_ready[g]),
            .out_data   (wake2_data[g])
        );
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy_q      <= '0;
            rdy1_q      <= '0;
            rdy2_q      <= '0;
            head_q      <= '0;
            tail_q      <= '0;
            count_q     <= '0;
            issue_valid <= 1'b0;
        end else begin
            rdy1_q      <= wake1_ready;
            rdy2_q      <= wake2_ready;
            issue_valid <= grant_valid;
            if (grant_valid) begin
                busy_q[grant_index] <= 1'b0;
            end
            if (alloc) begin
                busy_q[tail_q] <= 1'b1;
                rdy1_q[tail_q] <= src1_ready;  // overrides the wakeup above
                rdy2_q[tail_q] <= src2_ready;
                tail_q         <= ptr_inc(tail_q);
            end
            if (retire) begin
                head_q <= ptr_inc(head_q);
            end
            count_q <= count_q + CNT_W'(alloc) - CNT_W'(retire);
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < DEPTH; i++) begin
            data1_q[i] <= wake1_data[i];
            data2_q[i] <= wake2_data[i];
        end
        if (alloc) begin
            pc_q[tail_q]    <= dispatch_pc;
            rd_q[tail_q]    <= dispatch_rd;
            op_q[tail_q]    <= dispatch_op;
            tag1_q[tail_q]  <= src1_tag;
            tag2_q[tail_q]  <= src2_tag;
            data1_q[tail_q] <= src1_data;
            data2_q[tail_q] <= src2_data;
        end
        if (grant_valid) begin
            issue_pc   <= pc_q[grant_index];
            issue_rd   <= rd_q[grant_index];
            issue_op   <= op_q[grant_index];
            issue_src1 <= data1_q[grant_index];
            issue_src2 <= data2_q[grant_index];
        end
    end

endmodule

// File: src/rs_issue_select.sv
`timescale 1ns/1ns

module rs_issue_select #(
    parameter int DEPTH = 16
) (
    input  logic [DEPTH-1:0]         ready,
    input  logic [$clog2(DEPTH)-1:0] head,
    output logic                     grant_valid,
    output logic [$clog2(DEPTH)-1:0] grant_index
);

    localparam int PTR_W = $clog2(DEPTH);

    always_comb begin
        int idx;
        grant_valid = 1'b0;
        grant_index = head;
        // walk from head toward tail, oldest first
        for (int k = 0; k < DEPTH; k++) begin
            idx = (int'(head) + k) % DEPTH;
            if (!grant_valid && ready[idx]) begin
                grant_valid = 1'b1;
                grant_index = PTR_W'(idx);
            end
        end
    end

endmodule

// File: src/rs_tag_match.sv
`timescale 1ns/1ns

module rs_tag_match (
    input  logic [rs_div_pkg::TAG_W-1:0]  tag,
    input  logic                          in_ready,
    input  logic [rs_div_pkg::DATA_W-1:0] in_data,
    input  logic                          alu_valid,
    input  logic [rs_div_pkg::TAG_W-1:0]  alu_dest,
    input  logic [rs_div_pkg::DATA_W-1:0] alu_result,
    input  logic                          mul_valid,
    input  logic [rs_div_pkg::TAG_W-1:0]  mul_dest,
    input  logic [rs_div_pkg::DATA_W-1:0] mul_result,
    input  logic                          div_valid,
    input  logic [rs_div_pkg::TAG_W-1:0]  div_dest,
    input  logic [rs_div_pkg::DATA_W-1:0] div_result,
    input  logic                          load_valid,
    input  logic [rs_div_pkg::TAG_W-1:0]  load_tag,
    input  logic [rs_div_pkg::DATA_W-1:0] load_data,
    output logic                          out_ready,
    output logic [rs_div_pkg::DATA_W-1:0] out_data
);

    logic [rs_div_pkg::BUS_COUNT-1:0] bus_valid;
    logic [rs_div_pkg::TAG_W-1:0]     bus_tag  [rs_div_pkg::BUS_COUNT];
    logic [rs_div_pkg::DATA_W-1:0]    bus_data [rs_div_pkg::BUS_COUNT];

    assign bus_valid[rs_div_pkg::BUS_ALU]  = alu_valid;
    assign bus_valid[rs_div_pkg::BUS_MUL]  = mul_valid;
    assign bus_valid[rs_div_pkg::BUS_DIV]  = div_valid;
    assign bus_valid[rs_div_pkg::BUS_LOAD] = load_valid;

    assign bus_tag[rs_div_pkg::BUS_ALU]  = alu_dest;
    assign bus_tag[rs_div_pkg::BUS_MUL]  = mul_dest;
    assign bus_tag[rs_div_pkg::BUS_DIV]  = div_dest;
    assign bus_tag[rs_div_pkg::BUS_LOAD] = load_tag;

    assign bus_data[rs_div_pkg::BUS_ALU]  = alu_result;
    assign bus_data[rs_div_pkg::BUS_MUL]  = mul_result;
    assign bus_data[rs_div_pkg::BUS_DIV]  = div_result;
    assign bus_data[rs_div_pkg::BUS_LOAD] = load_data;

    always_comb begin
        out_ready = in_ready;
        out_data  = in_data;
        if (!in_ready) begin
            // scan down so the highest priority bus is applied last
            for (int b = rs_div_pkg::BUS_COUNT - 1; b >= 0; b--) begin
                if (bus_valid[b] && bus_tag[b] == tag) begin
                    out_ready = 1'b1;
                    out_data  = bus_data[b];
                end
            end
        end
    end

endmodule

// File: verification/rs_div_model.svh
typedef struct packed {
    logic                          live;  // not yet issued
    logic [rs_div_pkg::PC_W-1:0]   pc;
    logic [rs_div_pkg::TAG_W-1:0]  rd;
    logic [3:0]                    op;
    logic [rs_div_pkg::TAG_W-1:0]  tag1;
    logic                          rdy1;
    logic [rs_div_pkg::DATA_W-1:0] data1;
    logic [rs_div_pkg::TAG_W-1:0]  tag2;
    logic                          rdy2;
    logic [rs_div_pkg::DATA_W-1:0] data2;
} model_entry_t;

model_entry_t model_q[$];  // oldest at index 0
model_entry_t exp_issue;
logic         exp_valid = 1'b0;
logic [31:0]  rng_state = 32'h6e02_3ee4;

function automatic logic [31:0] lcg_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
endfunction

// first valid match in ALU, MUL, DIV, LOAD order
function automatic logic [32:0] snoop(input logic [7:0] tag, input logic rdy,
                                      input logic [31:0] data);
    return rdy                             ? {1'b1, data} :
           (alu_valid  && alu_dest == tag) ? {1'b1, alu_result} :
           (mul_valid  && mul_dest == tag) ? {1'b1, mul_result} :
           (div_valid  && div_dest == tag) ? {1'b1, div_result} :
           (load_valid && load_tag == tag) ? {1'b1, load_data} : {1'b0, data};
endfunction

task automatic model_step();
    model_entry_t e;
    int           grant;
    logic         alloc;
    logic         retire;
    grant  = -1;
    retire = 1'b0;
    alloc  = dispatch && model_q.size() < DEPTH;
    for (int i = 0; i < model_q.size(); i++) begin
        e = model_q[i];
        if (i == 0) begin
            retire = !e.live;  // freed head slot leaves the buffer
        end
        if (grant < 0 && e.live && e.rdy1 && e.rdy2) begin
            grant     = i;
            exp_issue = e;
            e.live    = 1'b0;
        end
        {e.rdy1, e.data1} = snoop(e.tag1, e.rdy1, e.data1);
        {e.rdy2, e.data2} = snoop(e.tag2, e.rdy2, e.data2);
        model_q[i] = e;
    end
    exp_valid = (grant >= 0);
    if (retire) begin
        model_q.delete(0);
    end
    if (alloc) begin
        e.live = 1'b1;
        e.pc   = dispatch_pc;
        e.rd   = dispatch_rd;
        e.op   = dispatch_op;
        e.tag1 = src1_tag;
        e.tag2 = src2_tag;
        {e.rdy1, e.data1} = snoop(src1_tag, src1_ready, src1_data);  // capture at dispatch
        {e.rdy2, e.data2} = snoop(src2_tag, src2_ready, src2_data);
        model_q.push_back(e);
        accepted++;
    end
endtask

// File: verification/rs_div_tb.sv
`timescale 1ns/1ns

module rs_div_tb;

    localparam int DEPTH      = 8;
    localparam int CLK_PERIOD = 4;
    localparam int RANDOM_OPS = 400;
    localparam int WATCHDOG   = 200 * (RANDOM_OPS + DEPTH + 8) + 1000;  // cycles

    logic clk = 1'b0;
    logic reset = 1'b1;
    logic dispatch = 1'b0, src1_ready = 1'b0, src2_ready = 1'b0;
    logic alu_valid = 1'b0, mul_valid = 1'b0, div_valid = 1'b0, load_valid = 1'b0;
    logic [rs_div_pkg::TAG_W-1:0] dispatch_rd = '0, src1_tag = '0, src2_tag = '0;
    logic [rs_div_pkg::TAG_W-1:0] alu_dest = '0, mul_dest = '0, div_dest = '0, load_tag = '0;
    logic [rs_div_pkg::DATA_W-1:0] src1_data = '0, src2_data = '0, alu_result = '0;
    logic [rs_div_pkg::DATA_W-1:0] mul_result = '0, div_result = '0, load_data = '0;
    logic [rs_div_pkg::PC_W-1:0] dispatch_pc = '0;
    rs_div_pkg::div_op_e dispatch_op = rs_div_pkg::OP_DIV;
    logic issue_valid, full;
    logic [rs_div_pkg::PC_W-1:0] issue_pc;
    logic [rs_div_pkg::TAG_W-1:0] issue_rd;
    logic [rs_div_pkg::DATA_W-1:0] issue_src1, issue_src2;
    rs_div_pkg::div_op_e issue_op;
    int errors = 0, mark = 0, passed = 0, failed = 0;
    int accepted = 0, issued = 0;

    `include "rs_div_model.svh"

    rs_div #(.DEPTH(DEPTH)) dut (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check(input logic [127:0] got, input logic [127:0] want, input string what);
        if (got !== want) begin
            $display("CHECK FAILED at %0t ns: %s got %0h expected %0h", $time, what, got, want);
            errors++;
        end
    endtask

    always @(posedge clk) begin
        if (!reset) begin
            model_step();
        end
    end

    always @(negedge clk) begin
        if (!reset) begin
            check(issue_valid, exp_valid, "issue_valid");
            check(full, model_q.size() == DEPTH, "full");
            if (exp_valid) begin
                check({issue_pc, issue_rd, issue_op, issue_src1, issue_src2},
                      {exp_issue.pc, exp_issue.rd, exp_issue.op, exp_issue.data1, exp_issue.data2},
                      "issue packet");
            end
            issued += issue_valid;
        end
    end

    task automatic tick();
        @(posedge clk);
        #1;
        {dispatch, alu_valid, mul_valid, div_valid, load_valid} = '0;
    endtask

    task automatic send(input logic [7:0] t1, input logic r1, input logic [7:0] t2, input logic r2);
        dispatch    = 1'b1;
        dispatch_pc = lcg_next();
        dispatch_rd = 8'(lcg_next() >> 24);
        dispatch_op = rs_div_pkg::div_op_e'(rs_div_pkg::OP_DIV + (lcg_next() >> 30));
        {src1_tag, src1_ready, src1_data} = {t1, r1, lcg_next()};
        {src2_tag, src2_ready, src2_data} = {t2, r2, lcg_next()};
    endtask

    // bus b carries tag + b*step and value base + b
    task automatic broadcast(input logic [3:0] valid, input logic [7:0] tag,
                             input logic [7:0] step, input logic [31:0] base);
        {load_valid, div_valid, mul_valid, alu_valid} = valid;
        alu_dest   = tag;
        mul_dest   = tag + step;
        div_dest   = tag + 8'd2 * step;
        load_tag   = tag + 8'd3 * step;
        alu_result = base;
        mul_result = base + 1;
        div_result = base + 2;
        load_data  = base + 3;
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (issued != accepted && n < 600) begin
            broadcast(4'b0001, 8'(n), 8'h00, lcg_next());  // sweep every tag
            tick();
            n++;
        end
        if (issued != accepted) begin
            $display("drain timed out: %0d issued of %0d dispatched", issued, accepted);
            errors++;
        end
    endtask

    task automatic finish_test(input string name);
        if (errors == mark) begin
            passed++;
        end else begin
            failed++;
        end
        $display("%-16s %0d mismatches", name, errors - mark);
        mark = errors;
    endtask

    initial begin
        logic [31:0] r;
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
        repeat (6) tick();
        finish_test("reset_state");

        send(8'h01, 1'b1, 8'h02, 1'b1);
        tick();
        drain();
        finish_test("ready_dispatch");

        send(8'h21, 1'b0, 8'h22, 1'b1);
        tick();
        broadcast(4'b0000, 8'h21, 8'h00, 32'hdead_0000);  // valid low
        tick();
        broadcast(4'b1111, 8'h31, 8'h01, 32'hbeef_0000);
        tick();
        broadcast(4'b0100, 8'h21, 8'h00, 32'h0000_d1d1);
        tick();
        drain();
        finish_test("wakeup");

        send(8'h40, 1'b0, 8'h40, 1'b0);
        broadcast(4'b1111, 8'h40, 8'h00, 32'h0000_a100);  // ALU should win
        tick();
        send(8'h44, 1'b0, 8'h44, 1'b0);
        broadcast(4'b1110, 8'h44, 8'h00, 32'h0000_b200);
        tick();
        drain();
        finish_test("dispatch_capture");

        repeat (DEPTH + 1) begin
            send(8'h50, 1'b0, 8'h51, 1'b0);  // last one lands while full
            tick();
        end
        broadcast(4'b0011, 8'h50, 8'h01, 32'h0000_5000);
        tick();
        drain();
        finish_test("full_order");

        repeat (RANDOM_OPS) begin
            r = lcg_next();
            if (r[31] && !full) begin
                send(8'(r[11:8]), r[30], 8'(r[15:12]), r[29]);
            end
            broadcast(r[27:24], 8'(r[7:4]), 8'(r[17:16]), lcg_next());
            tick();
        end
        drain();
        finish_test("random_traffic");

        $display("tests passed %0d, failed %0d", passed, failed);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin
        #(CLK_PERIOD * WATCHDOG);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG);
        $display("Test FAILED");
        $finish;
    end

endmodule
